/* gpio_defs.svh */
`ifndef GPIO_DEFS_SVH
`define GPIO_DEFS_SVH

// --------------------
// sizing
// --------------------

// default number of pins, 1 to 32 supported
`define GPIO_IO_NUM       32
// apb data bus width
`define GPIO_APB_WIDTH    32
// apb byte address width
`define GPIO_ADDR_WIDTH   8

// --------------------
// register map, byte offsets
// --------------------

// offsets below this hit config register offset/4
`define GPIO_CFG_LIMIT    8'h80
`define GPIO_ADDR_INTR    8'h80
`define GPIO_ADDR_GPIN    8'h90
`define GPIO_ADDR_GPOUT   8'hA0

// output register value after reset
`define GPIO_OUT_RESET    32'h0000_5A5A

`endif

/* gpio_bus_pkg.sv */
`include "gpio_defs.svh"

package gpio_bus_pkg;

   // --------------------
   // apb request side
   // --------------------

   // everything the master drives toward the slave
   typedef struct packed {
      logic                         psel;
      logic                         penable;
      logic                         pwrite;
      logic [`GPIO_ADDR_WIDTH-1:0]  paddr;
      logic [`GPIO_APB_WIDTH-1:0]   pwdata;
   } apb_req_t;

   // --------------------
   // address decode
   // --------------------

   // target of the current access
   typedef enum logic [2:0] {
      // per-pin config byte, index is paddr/4
      sel_cfg   = 3'd0,
      // interrupt status, write ones to clear
      sel_intr  = 3'd1,
      // synchronized pin inputs
      sel_gpin  = 3'd2,
      // output data register
      sel_gpout = 3'd3,
      // unmapped, reads as zero
      sel_none  = 3'd4
   } reg_sel_e;

endpackage

/* gpio_cfg_pkg.sv */
`include "gpio_defs.svh"

package gpio_cfg_pkg;

   // --------------------
   // interrupt type
   // --------------------

   // codes 5 and 6 are unused and behave as disabled
   typedef enum logic [2:0] {
      int_level_high = 3'd0,
      int_level_low  = 3'd1,
      int_edge_pos   = 3'd2,
      int_edge_neg   = 3'd3,
      int_edge_both  = 3'd4,
      int_disabled   = 3'd7
   } int_type_e;

   // --------------------
   // per-pin config byte
   // --------------------

   // bit 7 down to bit 0 as seen on the bus
   typedef struct packed {
      int_type_e  int_type;
      // kept and read back, no function
      logic       rsvd;
      logic       int_en;
      logic       oe_en;
      logic       in_en;
      logic       out_en;
   } pin_cfg_t;

   // one config byte per pin, always sized for the full 32
   typedef pin_cfg_t [`GPIO_IO_NUM-1:0] pin_cfg_vec_t;

endpackage

/* gpio_input_sync.sv */
`include "gpio_defs.svh"

module gpio_input_sync #(
   parameter int IO_NUM = `GPIO_IO_NUM
) (
   input  logic              PCLK,
   input  logic              aresetn,
   input  logic [IO_NUM-1:0] pin_i,
   output logic [IO_NUM-1:0] cur_o,
   output logic [IO_NUM-1:0] prev_o
);

   // first synchronizer stage, may go metastable
   logic [IO_NUM-1:0] meta_q;
   // second stage, newest stable sample
   logic [IO_NUM-1:0] cur_q;
   // one cycle older, for edge detection
   logic [IO_NUM-1:0] prev_q;

   // --------------------
   // sample chain
   // --------------------

   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         meta_q <= '0;
         cur_q  <= '0;
         prev_q <= '0;
      end
      else
      begin
         meta_q <= pin_i;
         cur_q  <= meta_q;
         prev_q <= cur_q;
      end
   end

   // an edge shows as cur and prev differing for one cycle
   assign cur_o  = cur_q;
   assign prev_o = prev_q;

endmodule

/* gpio_apb_regs.sv */
`include "gpio_defs.svh"

module gpio_apb_regs #(
   parameter int IO_NUM = `GPIO_IO_NUM
) (
   input  logic                         PCLK,
   input  logic                         aresetn,
   input  gpio_bus_pkg::apb_req_t       req_i,
   input  logic [IO_NUM-1:0]            pin_cur_i,
   input  logic [IO_NUM-1:0]            irq_status_i,
   output gpio_cfg_pkg::pin_cfg_vec_t   cfg_o,
   output logic [IO_NUM-1:0]            irq_clr_o,
   output logic [IO_NUM-1:0]            gpio_out_o,
   output logic [IO_NUM-1:0]            gpio_oe_o,
   output logic [`GPIO_APB_WIDTH-1:0]   prdata_o,
   output logic                         pready_o,
   output logic                         pslverr_o
);
   import gpio_bus_pkg::*;
   import gpio_cfg_pkg::*;

   localparam logic [31:0] OUT_RST = `GPIO_OUT_RESET;

   reg_sel_e                    sel;
   logic                        wr_en;
   logic [4:0]                  cfg_idx;
   pin_cfg_vec_t                cfg_q;
   logic [IO_NUM-1:0]           out_q;
   logic [IO_NUM-1:0]           gpin_masked;
   logic [`GPIO_APB_WIDTH-1:0]  rd_data;

   // --------------------
   // address decode
   // --------------------

   assign wr_en   = req_i.psel & req_i.penable & req_i.pwrite;
   assign cfg_idx = req_i.paddr[6:2];

   always_comb
   begin
      if (req_i.paddr < `GPIO_CFG_LIMIT)
      begin
         sel = sel_cfg;
      end
      else
      begin
         case (req_i.paddr)
            `GPIO_ADDR_INTR:  sel = sel_intr;
            `GPIO_ADDR_GPIN:  sel = sel_gpin;
            `GPIO_ADDR_GPOUT: sel = sel_gpout;
            default:          sel = sel_none;
         endcase
      end
   end

   // --------------------
   // registers
   // --------------------

   // entries at or above IO_NUM are never written and stay zero
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         cfg_q <= '0;
         out_q <= OUT_RST[IO_NUM-1:0];
      end
      else if (wr_en)
      begin
         if (sel == sel_cfg && cfg_idx < IO_NUM)
         begin
            cfg_q[cfg_idx] <= pin_cfg_t'(req_i.pwdata[7:0]);
         end
         if (sel == sel_gpout)
         begin
            out_q <= req_i.pwdata[IO_NUM-1:0];
         end
      end
   end

   assign cfg_o = cfg_q;

   // write-one-to-clear, valid for the access cycle only
   assign irq_clr_o = (wr_en && sel == sel_intr) ? req_i.pwdata[IO_NUM-1:0] : '0;

   // --------------------
   // pin drive
   // --------------------

   always_comb
   begin
      for (int i = 0; i < IO_NUM; i++)
      begin
         gpio_out_o[i]  = out_q[i] & cfg_q[i].out_en;
         gpio_oe_o[i]   = cfg_q[i].oe_en & cfg_q[i].out_en;
         gpin_masked[i] = pin_cur_i[i] & cfg_q[i].in_en;
      end
   end

   // --------------------
   // read mux
   // --------------------

   always_comb
   begin
      rd_data = '0;
      case (sel)
         // unused pins hold zero so the full index range is safe
         sel_cfg:   rd_data[7:0]        = cfg_q[cfg_idx];
         sel_intr:  rd_data[IO_NUM-1:0] = irq_status_i;
         sel_gpin:  rd_data[IO_NUM-1:0] = gpin_masked;
         sel_gpout: rd_data[IO_NUM-1:0] = out_q;
         default:   rd_data             = '0;
      endcase
   end

   assign prdata_o  = rd_data;
   // zero wait state, never an error
   assign pready_o  = 1'b1;
   assign pslverr_o = 1'b0;

   // --------------------
   // checks
   // --------------------

   // with pready always high every access phase lasts one cycle
   a_no_wait: assert property (@(posedge PCLK) disable iff (!aresetn)
      (req_i.psel && req_i.penable) |=> !req_i.penable);

   // software must not program pins that were not built
   a_cfg_range: assert property (@(posedge PCLK) disable iff (!aresetn)
      (wr_en && sel == sel_cfg) |-> (cfg_idx < IO_NUM));

endmodule

/* gpio_irq_detect.sv */
`include "gpio_defs.svh"

module gpio_irq_detect #(
   parameter int IO_NUM = `GPIO_IO_NUM
) (
   input  logic                         PCLK,
   input  logic                         aresetn,
   input  logic [IO_NUM-1:0]            cur_i,
   input  logic [IO_NUM-1:0]            prev_i,
   input  gpio_cfg_pkg::pin_cfg_vec_t   cfg_i,
   input  logic [IO_NUM-1:0]            irq_clr_i,
   output logic [IO_NUM-1:0]            int_o,
   output logic                         int_or_o,
   output logic [IO_NUM-1:0]            irq_status_o
);
   import gpio_cfg_pkg::*;

   logic [IO_NUM-1:0] int_en;
   logic [IO_NUM-1:0] rise;
   logic [IO_NUM-1:0] fall;
   logic [IO_NUM-1:0] edge_pos_q;
   logic [IO_NUM-1:0] edge_neg_q;
   logic [IO_NUM-1:0] edge_both_q;
   logic [IO_NUM-1:0] int_sel;
   logic [IO_NUM-1:0] status_q;

   always_comb
   begin
      for (int i = 0; i < IO_NUM; i++)
      begin
         int_en[i] = cfg_i[i].int_en;
      end
   end

   assign rise = cur_i & ~prev_i;
   assign fall = ~cur_i & prev_i;

   // --------------------
   // edge latches
   // --------------------

   // a new edge beats a clear in the same cycle
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         edge_pos_q  <= '0;
         edge_neg_q  <= '0;
         edge_both_q <= '0;
      end
      else
      begin
         edge_pos_q  <= int_en & (rise | (edge_pos_q & ~irq_clr_i));
         edge_neg_q  <= int_en & (fall | (edge_neg_q & ~irq_clr_i));
         edge_both_q <= int_en & (rise | fall | (edge_both_q & ~irq_clr_i));
      end
   end

   // --------------------
   // type select
   // --------------------

   always_comb
   begin
      for (int i = 0; i < IO_NUM; i++)
      begin
         case (cfg_i[i].int_type)
            int_level_high: int_sel[i] = cur_i[i];
            int_level_low:  int_sel[i] = ~cur_i[i];
            int_edge_pos:   int_sel[i] = edge_pos_q[i];
            int_edge_neg:   int_sel[i] = edge_neg_q[i];
            int_edge_both:  int_sel[i] = edge_both_q[i];
            int_disabled:   int_sel[i] = 1'b0;
            // reserved codes 5 and 6
            default:        int_sel[i] = 1'b0;
         endcase
      end
   end

   assign int_o    = int_en & int_sel;
   assign int_or_o = |int_o;

   // --------------------
   // status register
   // --------------------

   // tracks int_o, except it only drops bits on a clear cycle
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         status_q <= '0;
      end
      else if (|irq_clr_i)
      begin
         status_q <= status_q & ~irq_clr_i;
      end
      else
      begin
         status_q <= int_o;
      end
   end

   assign irq_status_o = status_q;

   // a masked pin keeps no stale edge for when it is enabled again
   a_int_masked: assert property (@(posedge PCLK) disable iff (!aresetn)
      ((edge_pos_q | edge_neg_q | edge_both_q) & ~$past(int_en)) == '0);

endmodule

/* gpio_apb_top.sv */
`include "gpio_defs.svh"

module gpio_apb_top #(
   parameter int IO_NUM = `GPIO_IO_NUM
) (
   input  logic                         PCLK,
   input  logic                         aresetn,
   input  logic                         psel_i,
   input  logic                         penable_i,
   input  logic                         pwrite_i,
   input  logic [`GPIO_ADDR_WIDTH-1:0]  paddr_i,
   input  logic [`GPIO_APB_WIDTH-1:0]   pwdata_i,
   output logic [`GPIO_APB_WIDTH-1:0]   prdata_o,
   output logic                         pready_o,
   output logic                         pslverr_o,
   input  logic [IO_NUM-1:0]            gpio_in_i,
   output logic [IO_NUM-1:0]            gpio_out_o,
   output logic [IO_NUM-1:0]            gpio_oe_o,
   output logic [IO_NUM-1:0]            int_o,
   output logic                         int_or_o
);
   import gpio_bus_pkg::*;
   import gpio_cfg_pkg::*;

   apb_req_t           req;
   pin_cfg_vec_t       cfg;
   logic [IO_NUM-1:0]  pin_cur;
   logic [IO_NUM-1:0]  pin_prev;
   logic [IO_NUM-1:0]  irq_clr;
   logic [IO_NUM-1:0]  irq_status;

   // bus inputs travel as one struct from here on
   assign req = '{psel:    psel_i,
                  penable: penable_i,
                  pwrite:  pwrite_i,
                  paddr:   paddr_i,
                  pwdata:  pwdata_i};

   gpio_input_sync #(.IO_NUM(IO_NUM)) u_input_sync (
      .PCLK    (PCLK),
      .aresetn (aresetn),
      .pin_i   (gpio_in_i),
      .cur_o   (pin_cur),
      .prev_o  (pin_prev)
   );

   gpio_apb_regs #(.IO_NUM(IO_NUM)) u_regs (
      .PCLK         (PCLK),
      .aresetn      (aresetn),
      .req_i        (req),
      .pin_cur_i    (pin_cur),
      .irq_status_i (irq_status),
      .cfg_o        (cfg),
      .irq_clr_o    (irq_clr),
      .gpio_out_o   (gpio_out_o),
      .gpio_oe_o    (gpio_oe_o),
      .prdata_o     (prdata_o),
      .pready_o     (pready_o),
      .pslverr_o    (pslverr_o)
   );

   gpio_irq_detect #(.IO_NUM(IO_NUM)) u_irq_detect (
      .PCLK         (PCLK),
      .aresetn      (aresetn),
      .cur_i        (pin_cur),
      .prev_i       (pin_prev),
      .cfg_i        (cfg),
      .irq_clr_i    (irq_clr),
      .int_o        (int_o),
      .int_or_o     (int_or_o),
      .irq_status_o (irq_status)
   );

endmodule

/* gpio_checker.sv */
`include "gpio_defs.svh"

module gpio_checker #(
   parameter int IO_NUM = `GPIO_IO_NUM
) (
   input  logic                         PCLK,
   input  logic                         aresetn,
   input  logic [`GPIO_ADDR_WIDTH-1:0]  paddr_i,
   input  logic [`GPIO_APB_WIDTH-1:0]   prdata_i,
   input  logic                         pready_i,
   input  logic                         pslverr_i,
   input  logic [IO_NUM-1:0]            gpio_out_i,
   input  logic [IO_NUM-1:0]            gpio_oe_i,
   input  logic [IO_NUM-1:0]            int_i,
   input  logic                         int_or_i,
   input  int                           test_id_i,
   input  logic                         rd_chk_i,
   input  logic [`GPIO_APB_WIDTH-1:0]   exp_rdata_i,
   input  logic                         pin_chk_i,
   input  logic [IO_NUM-1:0]            exp_out_i,
   input  logic [IO_NUM-1:0]            exp_oe_i,
   input  logic [IO_NUM-1:0]            exp_int_i,
   output int                           err_cnt_o,
   output int                           chk_cnt_o
);
   timeunit 1ns;
   timeprecision 100ps;

   int err_cnt = 0;
   int chk_cnt = 0;

   function automatic string test_name(input int id);
      case (id)
         1:       return "reset";
         2:       return "cfg_readback";
         3:       return "output_drive";
         4:       return "input_read";
         5:       return "level_irq";
         6:       return "edge_irq";
         default: return "idle";
      endcase
   endfunction

   task automatic compare_value(input string what, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
      chk_cnt++;
      if (act_v !== exp_v)
      begin
         err_cnt++;
         $display("Fail %s: %s expected %h actual %h",
                  test_name(test_id_i), what, exp_v, act_v);
      end
   endtask

   // --------------------
   // compare
   // --------------------

   // mid-cycle, well away from the drive edge
   always @(negedge PCLK)
   begin
      if (aresetn)
      begin
         // zero wait state bus, checked every cycle
         compare_value("pready_o", 32'd1, 32'(pready_i));
         compare_value("pslverr_o", 32'd0, 32'(pslverr_i));
         if (rd_chk_i)
         begin
            compare_value($sformatf("prdata_o at %h", paddr_i), exp_rdata_i, prdata_i);
         end
         if (pin_chk_i)
         begin
            compare_value("gpio_out_o", 32'(exp_out_i), 32'(gpio_out_i));
            compare_value("gpio_oe_o", 32'(exp_oe_i), 32'(gpio_oe_i));
            compare_value("int_o", 32'(exp_int_i), 32'(int_i));
            compare_value("int_or_o", 32'(|exp_int_i), 32'(int_or_i));
         end
      end
   end

   assign err_cnt_o = err_cnt;
   assign chk_cnt_o = chk_cnt;

endmodule

/* tb_gpio_apb.sv */
`include "gpio_defs.svh"

module tb_gpio_apb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int IO_NUM  = `GPIO_IO_NUM;
   localparam int DRV_DLY = 2;
   // the sequence below takes about 900 cycles
   localparam int MAX_CYCLES = 4000;

   logic                        PCLK;
   logic                        aresetn;
   logic                        psel;
   logic                        penable;
   logic                        pwrite;
   logic [`GPIO_ADDR_WIDTH-1:0] paddr;
   logic [`GPIO_APB_WIDTH-1:0]  pwdata;
   logic [`GPIO_APB_WIDTH-1:0]  prdata;
   logic                        pready;
   logic                        pslverr;
   logic [IO_NUM-1:0]           gpio_in;
   logic [IO_NUM-1:0]           gpio_out;
   logic [IO_NUM-1:0]           gpio_oe;
   logic [IO_NUM-1:0]           int_vec;
   logic                        int_or;

   // strobes and expected values for the checker
   int                          test_id;
   logic                        rd_chk;
   logic                        pin_chk;
   logic [`GPIO_APB_WIDTH-1:0]  exp_rdata;
   logic [IO_NUM-1:0]           exp_out;
   logic [IO_NUM-1:0]           exp_oe;
   logic [IO_NUM-1:0]           exp_int;
   int                          err_cnt;
   int                          chk_cnt;
   int                          cycle_cnt = 0;
   int                          seed = 32'h7f61_2510;

   // register and latch model
   logic [7:0]                  cfg_m [IO_NUM];
   logic [IO_NUM-1:0]           out_m;
   logic [IO_NUM-1:0]           pos_m;
   logic [IO_NUM-1:0]           neg_m;
   logic [IO_NUM-1:0]           both_m;

   // --------------------
   // reference model
   // --------------------

   // one config bit of every pin as a vector
   function automatic logic [IO_NUM-1:0] cfg_bits(input int pos);
      logic [IO_NUM-1:0] r;
      for (int i = 0; i < IO_NUM; i++)
      begin
         r[i] = cfg_m[i][pos];
      end
      return r;
   endfunction

   function automatic logic [IO_NUM-1:0] ref_int();
      logic [IO_NUM-1:0] r;
      for (int i = 0; i < IO_NUM; i++)
      begin
         // type field is config bits 7:5
         case (cfg_m[i][7:5])
            3'd0:    r[i] = gpio_in[i];
            3'd1:    r[i] = ~gpio_in[i];
            3'd2:    r[i] = pos_m[i];
            3'd3:    r[i] = neg_m[i];
            3'd4:    r[i] = both_m[i];
            default: r[i] = 1'b0;
         endcase
      end
      return r & cfg_bits(3);
   endfunction

   function automatic logic [31:0] ref_rdata(input logic [7:0] addr);
      logic [31:0] r;
      r = '0;
      if (addr < `GPIO_CFG_LIMIT)
      begin
         r[7:0] = cfg_m[addr[6:2]];
      end
      else
      begin
         case (addr)
            `GPIO_ADDR_INTR:  r[IO_NUM-1:0] = ref_int();
            `GPIO_ADDR_GPIN:  r[IO_NUM-1:0] = gpio_in & cfg_bits(1);
            `GPIO_ADDR_GPOUT: r[IO_NUM-1:0] = out_m;
            default:          r = '0;
         endcase
      end
      return r;
   endfunction

   task automatic model_write(input logic [7:0] addr, input logic [31:0] data);
      if (addr < `GPIO_CFG_LIMIT)
      begin
         cfg_m[addr[6:2]] = data[7:0];
      end
      else if (addr == `GPIO_ADDR_GPOUT)
      begin
         out_m = data[IO_NUM-1:0];
      end
      else if (addr == `GPIO_ADDR_INTR)
      begin
         pos_m  = pos_m & ~data[IO_NUM-1:0];
         neg_m  = neg_m & ~data[IO_NUM-1:0];
         both_m = both_m & ~data[IO_NUM-1:0];
      end
      // latches stay clear while int_en is low
      pos_m  = pos_m & cfg_bits(3);
      neg_m  = neg_m & cfg_bits(3);
      both_m = both_m & cfg_bits(3);
   endtask

   // --------------------
   // stimulus
   // --------------------

   task automatic next_cycle();
      @(posedge PCLK);
      #(DRV_DLY);
   endtask

   task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data);
      next_cycle();
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = data;
      next_cycle();
      penable   = 1'b1;
      rd_chk    = ~wr;
      exp_rdata = ref_rdata(addr);
      next_cycle();
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      rd_chk  = 1'b0;
      if (wr)
      begin
         model_write(addr, data);
      end
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      apb_access(1'b1, addr, data);
   endtask

   task automatic apb_read(input logic [7:0] addr);
      apb_access(1'b0, addr, 32'd0);
   endtask

   task automatic set_pins(input logic [IO_NUM-1:0] pins);
      logic [IO_NUM-1:0] rise;
      logic [IO_NUM-1:0] fall;
      rise = pins & ~gpio_in & cfg_bits(3);
      fall = ~pins & gpio_in & cfg_bits(3);
      next_cycle();
      gpio_in = pins;
      pos_m   = pos_m | rise;
      neg_m   = neg_m | fall;
      both_m  = both_m | rise | fall;
      // three stages of latency, one spare
      repeat (4) next_cycle();
   endtask

   task automatic check_pins();
      pin_chk = 1'b1;
      exp_out = out_m & cfg_bits(0);
      exp_oe  = cfg_bits(2) & cfg_bits(0);
      exp_int = ref_int();
      next_cycle();
      pin_chk = 1'b0;
   endtask

   // --------------------
   // clock, dut, checker
   // --------------------

   initial
   begin
      PCLK = 1'b0;
      forever #10 PCLK = ~PCLK;
   end

   gpio_apb_top #(.IO_NUM(IO_NUM)) u_gpio_apb_top (
      .PCLK      (PCLK),
      .aresetn   (aresetn),
      .psel_i    (psel),
      .penable_i (penable),
      .pwrite_i  (pwrite),
      .paddr_i   (paddr),
      .pwdata_i  (pwdata),
      .prdata_o  (prdata),
      .pready_o  (pready),
      .pslverr_o (pslverr),
      .gpio_in_i (gpio_in),
      .gpio_out_o(gpio_out),
      .gpio_oe_o (gpio_oe),
      .int_o     (int_vec),
      .int_or_o  (int_or)
   );

   gpio_checker #(.IO_NUM(IO_NUM)) u_checker (
      .PCLK        (PCLK),
      .aresetn     (aresetn),
      .paddr_i     (paddr),
      .prdata_i    (prdata),
      .pready_i    (pready),
      .pslverr_i   (pslverr),
      .gpio_out_i  (gpio_out),
      .gpio_oe_i   (gpio_oe),
      .int_i       (int_vec),
      .int_or_i    (int_or),
      .test_id_i   (test_id),
      .rd_chk_i    (rd_chk),
      .exp_rdata_i (exp_rdata),
      .pin_chk_i   (pin_chk),
      .exp_out_i   (exp_out),
      .exp_oe_i    (exp_oe),
      .exp_int_i   (exp_int),
      .err_cnt_o   (err_cnt),
      .chk_cnt_o   (chk_cnt)
   );

   always @(posedge PCLK)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES)
      begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("Test FAILED");
         $finish;
      end
   end

   // --------------------
   // test sequence
   // --------------------

   initial
   begin
      logic [31:0] rnd;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      gpio_in   = '0;
      test_id   = 0;
      rd_chk    = 1'b0;
      pin_chk   = 1'b0;
      exp_rdata = '0;
      exp_out   = '0;
      exp_oe    = '0;
      exp_int   = '0;
      rnd       = `GPIO_OUT_RESET;
      out_m     = rnd[IO_NUM-1:0];
      pos_m     = '0;
      neg_m     = '0;
      both_m    = '0;
      for (int i = 0; i < IO_NUM; i++)
      begin
         cfg_m[i] = '0;
      end
      aresetn = 1'b0;
      repeat (10) @(posedge PCLK);
      #(DRV_DLY);
      aresetn = 1'b1;

      // values after reset
      test_id = 1;
      for (int i = 0; i < 32; i++)
      begin
         apb_read(8'(i * 4));
      end
      apb_read(`GPIO_ADDR_INTR);
      apb_read(`GPIO_ADDR_GPIN);
      apb_read(`GPIO_ADDR_GPOUT);
      check_pins();

      // config bytes read back, holes read zero
      test_id = 2;
      for (int i = 0; i < 32; i++)
      begin
         apb_write(8'(i * 4), $random(seed));
      end
      for (int i = 0; i < 32; i++)
      begin
         apb_read(8'(i * 4));
      end
      apb_read(8'h84);
      apb_read(8'hB0);
      apb_read(8'hFC);

      test_id = 3;
      repeat (8)
      begin
         rnd = $random(seed);
         apb_write({1'b0, rnd[4:0], 2'b00}, $random(seed));
         apb_write(`GPIO_ADDR_GPOUT, $random(seed));
         check_pins();
         apb_read(`GPIO_ADDR_GPOUT);
      end

      test_id = 4;
      repeat (8)
      begin
         set_pins($random(seed));
         apb_read(`GPIO_ADDR_GPIN);
         apb_read(`GPIO_ADDR_INTR);
         check_pins();
      end

      // lower half level high, upper half level low
      test_id = 5;
      for (int i = 0; i < 32; i++)
      begin
         apb_write(8'(i * 4), (i < 16) ? 32'h0A : 32'h2A);
      end
      repeat (6)
      begin
         set_pins($random(seed));
         check_pins();
         apb_read(`GPIO_ADDR_INTR);
      end
      for (int i = 0; i < 8; i++)
      begin
         apb_write(8'(i * 4), 32'h02);
      end
      set_pins($random(seed));
      check_pins();

      test_id = 6;
      set_pins('0);
      for (int i = 0; i < 32; i++)
      begin
         // rising, falling, both, then type 7 with int_en set
         case (i % 4)
            0:       rnd = 32'h4A;
            1:       rnd = 32'h6A;
            2:       rnd = 32'h8A;
            default: rnd = 32'hEA;
         endcase
         apb_write(8'(i * 4), rnd);
      end
      apb_write(`GPIO_ADDR_INTR, '1);
      check_pins();
      repeat (6)
      begin
         set_pins($random(seed));
         check_pins();
         set_pins('0);
         check_pins();
         apb_read(`GPIO_ADDR_INTR);
         apb_write(`GPIO_ADDR_INTR, $random(seed));
         check_pins();
         apb_read(`GPIO_ADDR_INTR);
      end

      repeat (2) next_cycle();
      $display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0)
      begin
         $display("Test OK");
      end
      else
      begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

/* gpio_apb.f */
+incdir+.
gpio_bus_pkg.sv
gpio_cfg_pkg.sv
gpio_input_sync.sv
gpio_apb_regs.sv
gpio_irq_detect.sv
gpio_apb_top.sv
gpio_checker.sv
tb_gpio_apb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_gpio_apb
FILELIST  := gpio_apb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "no result found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
